// ==== sim/controlPatterns.txt ====
// Record count, then one line per test
// Columns: instruction, words after strobe, Decode, Execute, Memory or Writeback, Writeback
19
123450B7 3 68000 40040 40007 00000 // LUI
00001117 3 68000 401C0 40007 00000 // AUIPC
008000EF 3 70000 44100 40003 00000 // JAL
000100E7 3 50000 42100 40003 00000 // JALR
00208463 2 60000 41100 00000 00000 // BEQ
0020F463 2 60000 41100 00000 00000 // BGEU
00412183 4 50000 40140 40020 4000E // LW
00414183 4 50000 40140 40020 4000E // LBU
00310423 3 58000 40140 40010 00000 // SB
00312423 3 58000 40140 40010 00000 // SW
00108293 3 50000 40140 40007 00000 // ADDI
0010A293 3 50000 40440 40007 00000 // SLTI
0010C293 3 50000 40640 40007 00000 // XORI
00109293 3 50000 40340 40007 00000 // SLLI
4010D293 3 50000 40840 40007 00000 // SRAI
002082B3 3 48000 40100 40007 00000 // ADD
402082B3 3 48000 40200 40007 00000 // SUB
0020B2B3 3 48000 40500 40007 00000 // SLTU
0020D2B3 3 48000 40700 40007 00000 // SRL
4020D2B3 3 48000 40800 40007 00000 // SRA
0020E2B3 3 48000 40900 40007 00000 // OR
0020F2B3 3 48000 40A00 40007 00000 // AND
00000000 2 40000 40000 00000 00000 // Opcode zero
4020C2B3 2 40000 40000 00000 00000 // XOR with bit 30
40109293 2 40000 40000 00000 00000 // SLLI with bit 30

// ==== files.f ====
design/rvIsaPkg.sv
design/ctrlPkg.sv
design/instrDecoder.sv
design/controlWordGen.sv
design/phaseSequencer.sv
design/controlUnit.sv
sim/controlUnitAssertions.sv
sim/controlUnitTb.sv

// ==== Makefile ====
TOP = controlUnitTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -Mdir obj_dir -f files.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "No errors"

clean:
	rm -rf obj_dir

// ==== sim/controlUnitTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlUnitTb;

    localparam int maxPatterns = 32;
    localparam int recordLen   = 6; // ins, word count, four words
    localparam int resetCycles = 16;
    localparam int maxWait     = 10;

    logic               CLK;
    logic               RESET;
    logic [31:0]        ins;
    logic               insValid;
    logic               insReady;
    ctrlPkg::ctrlWord_t ctrl;

    logic [31:0]        patMem [0:recordLen*maxPatterns];
    ctrlPkg::ctrlWord_t idleExpected;
    int                 numPatterns;
    int                 errorCount;
    int                 cycleCount = 0;
    int                 cycleLimit = 1000;
    int unsigned        lcgState;

    controlUnit DUT
    (
        .CLK      (CLK),
        .RESET    (RESET),
        .ins      (ins),
        .insValid (insValid),
        .insReady (insReady),
        .ctrl     (ctrl)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("Run stopped at cycle limit %0d before all tests finished", cycleLimit);
            $display("Errors found");
            $finish;
        end
    end

    function automatic int unsigned nextRandom(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic checkWord(input ctrlPkg::ctrlWord_t expected, input string name);
        if (ctrl !== expected)
        begin
            $display("mismatch at %0t ns: %s expected %h got %h", $time, name, expected, ctrl);
            errorCount++;
        end
    endtask

    task automatic checkCycles(input int expected, input int actual);
        if (actual != expected)
        begin
            $display("mismatch at %0t ns: cycles to insReady expected %0d got %0d",
                     $time, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkReady(input logic expected, input string name);
        if (insReady !== expected)
        begin
            $display("mismatch at %0t ns: %s expected %b got %b", $time, name, expected, insReady);
            errorCount++;
        end
    endtask

    task automatic runInstruction(input int index);
        int                 base;
        int                 wordCount;
        int                 gap;
        int                 cycles;
        int                 errorsBefore;
        logic               ready;
        ctrlPkg::ctrlWord_t strobe;
        base         = 1 + index * recordLen;
        wordCount    = patMem[base + 1];
        errorsBefore = errorCount;
        strobe       = '0;
        lcgState     = nextRandom(lcgState);
        gap          = (lcgState >> 16) % 4;
        repeat (gap)
        begin
            @(negedge CLK);
            checkWord(idleExpected, "ctrl in idle gap");
            checkReady(1'b1, "insReady in idle gap");
        end
        @(posedge CLK);
        ins      <= patMem[base];
        insValid <= 1'b1;
        @(negedge CLK);
        checkReady(1'b1, "insReady before acceptance");
        @(posedge CLK); // Acceptance edge
        insValid <= 1'b0;
        cycles = 0;
        ready  = 1'b0;
        while (!ready && cycles < maxWait)
        begin
            @(negedge CLK);
            cycles++;
            if (cycles == 1)
                checkWord(strobe, "ctrl fetch strobe");
            else if (cycles <= wordCount + 1)
                checkWord(patMem[base + cycles][18:0], $sformatf("ctrl word %0d", cycles - 1));
            else
                checkWord(idleExpected, "ctrl after last word");
            ready = insReady;
        end
        if (!ready)
        begin
            $display("insReady did not return within %0d cycles of acceptance", maxWait);
            errorCount++;
        end
        else
            checkCycles(wordCount + 2, cycles);
        $display("test %0d ins %h cycles %0d gap %0d %s", index + 1, patMem[base], cycles, gap,
                 (errorCount == errorsBefore) ? "ok" : "FAILED");
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial
    begin
        CLK          = 1'b0;
        RESET        = 1'b1;
        ins          = '0;
        insValid     = 1'b0;
        errorCount   = 0;
        lcgState     = 32'd96054;
        idleExpected = '0;
        idleExpected.stall = 1'b1;
        $readmemh("sim/controlPatterns.txt", patMem);
        numPatterns = patMem[0]; // First entry is the record count
        if (numPatterns < 1 || numPatterns > maxPatterns)
        begin
            $display("Pattern file gave no usable record count");
            errorCount++;
            numPatterns = 0;
        end
        cycleLimit  = numPatterns * (6 + 3 + 1) + resetCycles + 20;
        repeat (resetCycles) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        checkWord(idleExpected, "ctrl after reset");
        checkReady(1'b1, "insReady after reset");
        $display("test 0 reset %s", (errorCount == 0) ? "ok" : "FAILED");
        for (int i = 0; i < numPatterns; i++)
            runInstruction(i);
        $display("tests run %0d, failed checks %0d", numPatterns + 1, errorCount);
        if (errorCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/controlUnitAssertions.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlUnitAssertions
(
    input logic               CLK,
    input logic               RESET,
    input logic               insValid,
    input logic               insReady,
    input ctrlPkg::ctrlWord_t ctrl
);

    // Memory strobes are one-hot per word
    memStrobesExclusive: assert property (@(posedge CLK) disable iff (RESET)
        !(ctrl.memRead && ctrl.memWrite))
        else $error("memRead and memWrite are high in the same cycle");

    readyOnlyWhenIdle: assert property (@(posedge CLK) disable iff (RESET)
        insReady |-> (ctrl == ctrlPkg::idleWord))
        else $error("insReady is high while ctrl is not the idle word");

    ////////////////////////////////////////
    // Fetch strobe lasts one cycle
    ////////////////////////////////////////
    strobeAfterAccept: assert property (@(posedge CLK) disable iff (RESET)
        (insReady && insValid) |=> !ctrl.stall ##1 ctrl.stall)
        else $error("stall is not low for exactly one cycle after acceptance");

endmodule

bind controlUnit controlUnitAssertions protocolChecks
(
    .CLK      (CLK),
    .RESET    (RESET),
    .insValid (insValid),
    .insReady (insReady),
    .ctrl     (ctrl)
);

`default_nettype wire

// ==== design/controlUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlUnit
(
    input  logic               CLK,
    input  logic               RESET,
    input  logic [31:0]        ins,
    input  logic               insValid,
    output logic               insReady,
    output ctrlPkg::ctrlWord_t ctrl
);

    logic [31:0]        insLatched;
    logic               insAccept;
    ctrlPkg::phase_t    phase;
    ctrlPkg::phase_t    nextPhase;
    ctrlPkg::ctrlWord_t nextWord;
    ctrlPkg::decoded_t  decoded;

    phaseSequencer sequencer
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .ins        (ins),
        .insValid   (insValid),
        .insReady   (insReady),
        .nextWord   (nextWord),
        .nextPhase  (nextPhase),
        .phase      (phase),
        .insLatched (insLatched),
        .insAccept  (insAccept),
        .ctrl       (ctrl)
    );

    instrDecoder decoder
    (
        .ins     (insLatched),
        .decoded (decoded)
    );

    controlWordGen wordGen
    (
        .phase     (phase),
        .decoded   (decoded),
        .insAccept (insAccept),
        .nextWord  (nextWord),
        .nextPhase (nextPhase)
    );

endmodule

`default_nettype wire

// ==== design/phaseSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module phaseSequencer
(
    input  logic               CLK,
    input  logic               RESET,
    input  logic [31:0]        ins,
    input  logic               insValid,
    output logic               insReady,
    input  ctrlPkg::ctrlWord_t nextWord,
    input  ctrlPkg::phase_t    nextPhase,
    output ctrlPkg::phase_t    phase,
    output logic [31:0]        insLatched,
    output logic               insAccept,
    output ctrlPkg::ctrlWord_t ctrl
);

    logic wordDrained; // Last word of previous instruction has left ctrl

    // First FETCH cycle still shows the final word, so wait one cycle
    assign insReady  = (phase == ctrlPkg::FETCH) && wordDrained;
    assign insAccept = insReady && insValid;

    ////////////////////////////////////////
    // Phase and control word registers
    ////////////////////////////////////////
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase       <= ctrlPkg::FETCH;
            ctrl        <= ctrlPkg::idleWord;
            wordDrained <= 1'b1;
        end
        else
        begin
            phase       <= nextPhase;
            ctrl        <= nextWord;
            wordDrained <= (phase == ctrlPkg::FETCH) && !insAccept;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (insAccept)
            insLatched <= ins; // Held until next acceptance
    end

endmodule

`default_nettype wire

// ==== design/controlWordGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlWordGen
(
    input  ctrlPkg::phase_t    phase,
    input  ctrlPkg::decoded_t  decoded,
    input  logic               insAccept,
    output ctrlPkg::ctrlWord_t nextWord,
    output ctrlPkg::phase_t    nextPhase
);

    always_comb
    begin
        nextWord  = ctrlPkg::idleWord;
        nextPhase = ctrlPkg::FETCH;
        case (phase)
            ctrlPkg::FETCH:
            begin
                if (insAccept)
                begin
                    nextWord.stall = 1'b0; // Fetch strobe
                    nextPhase      = ctrlPkg::DECODE;
                end
            end
            ctrlPkg::DECODE:
            begin
                nextWord.format = decoded.format; // NONE for unknown words
                nextPhase       = ctrlPkg::EXECUTE;
            end
            ctrlPkg::EXECUTE:
            begin
                if (decoded.kind != ctrlPkg::ILLEGAL)
                begin
                    nextWord.aluOp   = decoded.aluOp;
                    nextWord.aluSrc1 = decoded.aluSrc1;
                    nextWord.aluSrc2 = decoded.aluSrc2;
                end
                nextWord.jump    = (decoded.kind == ctrlPkg::JUMP);
                nextWord.jumpReg = (decoded.kind == ctrlPkg::JUMPREG);
                nextWord.branch  = (decoded.kind == ctrlPkg::BRANCH);
                case (decoded.kind)
                    ctrlPkg::ILLEGAL, ctrlPkg::BRANCH: nextPhase = ctrlPkg::FETCH;
                    ctrlPkg::LOAD, ctrlPkg::STORE:     nextPhase = ctrlPkg::MEMORY;
                    default:                           nextPhase = ctrlPkg::WRITEBACK;
                endcase
            end

            ////////////////////////////////////////
            // Memory and register write phases
            ////////////////////////////////////////
            ctrlPkg::MEMORY:
            begin
                nextWord.memRead  = (decoded.kind == ctrlPkg::LOAD);
                nextWord.memWrite = (decoded.kind == ctrlPkg::STORE);
                if (decoded.kind == ctrlPkg::LOAD)
                    nextPhase = ctrlPkg::WRITEBACK;
            end
            ctrlPkg::WRITEBACK:
            begin
                case (decoded.kind)
                    ctrlPkg::LOAD:
                    begin
                        nextWord.memToReg = 1'b1;
                        nextWord.writeSrc = 1'b1;
                        nextWord.regWrite = 1'b1;
                    end
                    ctrlPkg::UPPER, ctrlPkg::ALUIMM, ctrlPkg::ALUREG:
                    begin
                        nextWord.writeSrc = 1'b1; // ALU result
                        nextWord.regWrite = 1'b1;
                        nextWord.memSkip  = 1'b1;
                    end
                    ctrlPkg::JUMP, ctrlPkg::JUMPREG:
                    begin
                        nextWord.regWrite = 1'b1; // Link address
                        nextWord.memSkip  = 1'b1;
                    end
                    default:
                        nextWord = ctrlPkg::idleWord;
                endcase
            end
            default:
                nextPhase = ctrlPkg::FETCH;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/instrDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instrDecoder
(
    input  logic [31:0]       ins,
    output ctrlPkg::decoded_t decoded
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       altBit;

    assign opcode = ins[6:0];
    assign funct3 = ins[14:12];
    assign altBit = ins[rvIsaPkg::altFunct7Bit];

    always_comb
    begin
        decoded = '0; // Kind ILLEGAL, format NONE
        case (opcode)
            rvIsaPkg::opLui:
            begin
                decoded.kind    = ctrlPkg::UPPER;
                decoded.format  = rvIsaPkg::U;
                decoded.aluOp   = rvIsaPkg::COPY2;
                decoded.aluSrc2 = rvIsaPkg::IMM;
            end
            rvIsaPkg::opAuipc:
            begin
                decoded.kind    = ctrlPkg::UPPER;
                decoded.format  = rvIsaPkg::U;
                decoded.aluOp   = rvIsaPkg::ADD;
                decoded.aluSrc1 = rvIsaPkg::PC;
                decoded.aluSrc2 = rvIsaPkg::IMM;
            end
            rvIsaPkg::opJal:
            begin
                decoded.kind   = ctrlPkg::JUMP;
                decoded.format = rvIsaPkg::J;
                decoded.aluOp  = rvIsaPkg::ADD;
            end
            rvIsaPkg::opJalr:
            begin
                if (funct3 == rvIsaPkg::f3Jalr)
                begin
                    decoded.kind   = ctrlPkg::JUMPREG;
                    decoded.format = rvIsaPkg::I;
                    decoded.aluOp  = rvIsaPkg::ADD;
                end
            end
            rvIsaPkg::opBranch:
            begin
                decoded.kind   = ctrlPkg::BRANCH; // Any funct3, comparison lives in datapath
                decoded.format = rvIsaPkg::B;
                decoded.aluOp  = rvIsaPkg::ADD;
            end
            rvIsaPkg::opLoad:
            begin
                if (funct3 inside {rvIsaPkg::f3Lb, rvIsaPkg::f3Lh, rvIsaPkg::f3Lw,
                                   rvIsaPkg::f3Lbu, rvIsaPkg::f3Lhu})
                begin
                    decoded.kind    = ctrlPkg::LOAD;
                    decoded.format  = rvIsaPkg::I;
                    decoded.aluOp   = rvIsaPkg::ADD;
                    decoded.aluSrc2 = rvIsaPkg::IMM;
                end
            end
            rvIsaPkg::opStore:
            begin
                if (funct3 inside {rvIsaPkg::f3Sb, rvIsaPkg::f3Sh, rvIsaPkg::f3Sw})
                begin
                    decoded.kind    = ctrlPkg::STORE;
                    decoded.format  = rvIsaPkg::S;
                    decoded.aluOp   = rvIsaPkg::ADD;
                    decoded.aluSrc2 = rvIsaPkg::IMM;
                end
            end
            rvIsaPkg::opOpImm:
            begin
                decoded.kind    = ctrlPkg::ALUIMM;
                decoded.format  = rvIsaPkg::I;
                decoded.aluSrc2 = rvIsaPkg::IMM;
                case (funct3)
                    rvIsaPkg::f3AddSub: decoded.aluOp = rvIsaPkg::ADD; // Bit 30 is immediate
                    rvIsaPkg::f3Slt:    decoded.aluOp = rvIsaPkg::SLT;
                    rvIsaPkg::f3Sltu:   decoded.aluOp = rvIsaPkg::SLTU;
                    rvIsaPkg::f3Xor:    decoded.aluOp = rvIsaPkg::XOR;
                    rvIsaPkg::f3Or:     decoded.aluOp = rvIsaPkg::OR;
                    rvIsaPkg::f3And:    decoded.aluOp = rvIsaPkg::AND;
                    rvIsaPkg::f3Sll:
                    begin
                        if (altBit)
                            decoded = '0;
                        else
                            decoded.aluOp = rvIsaPkg::SLL;
                    end
                    default:
                    begin
                        if (altBit)
                            decoded.aluOp = rvIsaPkg::SRA;
                        else
                            decoded.aluOp = rvIsaPkg::SRL;
                    end
                endcase
            end
            rvIsaPkg::opOp:
            begin
                decoded.kind   = ctrlPkg::ALUREG;
                decoded.format = rvIsaPkg::R;
                if (altBit && !(funct3 inside {rvIsaPkg::f3AddSub, rvIsaPkg::f3SrlSra}))
                    decoded = '0; // Bit 30 only legal for SUB and SRA
                else
                begin
                    case (funct3)
                        rvIsaPkg::f3AddSub:
                            decoded.aluOp = altBit ? rvIsaPkg::SUB : rvIsaPkg::ADD;
                        rvIsaPkg::f3Sll:    decoded.aluOp = rvIsaPkg::SLL;
                        rvIsaPkg::f3Slt:    decoded.aluOp = rvIsaPkg::SLT;
                        rvIsaPkg::f3Sltu:   decoded.aluOp = rvIsaPkg::SLTU;
                        rvIsaPkg::f3Xor:    decoded.aluOp = rvIsaPkg::XOR;
                        rvIsaPkg::f3SrlSra:
                            decoded.aluOp = altBit ? rvIsaPkg::SRA : rvIsaPkg::SRL;
                        rvIsaPkg::f3Or:     decoded.aluOp = rvIsaPkg::OR;
                        default:            decoded.aluOp = rvIsaPkg::AND;
                    endcase
                end
            end
            default:
                decoded = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    typedef enum logic [2:0] {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK} phase_t;

    typedef enum logic [3:0] {
        ILLEGAL, // All-zero decode
        UPPER,
        JUMP,
        JUMPREG,
        BRANCH,
        LOAD,
        STORE,
        ALUIMM,
        ALUREG
    } instrKind_t;

    // Instruction class as seen by the control word tables
    typedef struct packed {
        instrKind_t          kind;
        rvIsaPkg::immFormat_t format;
        rvIsaPkg::aluOp_t     aluOp;
        rvIsaPkg::aluSrc1_t   aluSrc1;
        rvIsaPkg::aluSrc2_t   aluSrc2;
    } decoded_t;

    ////////////////////////////////////////
    // Control word to the datapath, MSB first
    ////////////////////////////////////////
    typedef struct packed {
        logic                 stall;
        rvIsaPkg::immFormat_t format;
        logic                 jump;
        logic                 jumpReg;
        logic                 branch;
        rvIsaPkg::aluOp_t     aluOp;
        rvIsaPkg::aluSrc1_t   aluSrc1;
        rvIsaPkg::aluSrc2_t   aluSrc2;
        logic                 memRead;
        logic                 memWrite;
        logic                 memToReg;
        logic                 writeSrc;
        logic                 regWrite;
        logic                 memSkip;
    } ctrlWord_t;

    localparam ctrlWord_t idleWord = ctrlWord_t'({1'b1, 18'd0});

endpackage

`default_nettype wire

// ==== design/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

    ////////////////////////////////////////
    // Major opcodes, instruction bits 6:0
    ////////////////////////////////////////
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;

    ////////////////////////////////////////
    // Funct3, instruction bits 14:12
    ////////////////////////////////////////
    localparam logic [2:0] f3Jalr   = 3'b000;

    localparam logic [2:0] f3Lb     = 3'b000;
    localparam logic [2:0] f3Lh     = 3'b001;
    localparam logic [2:0] f3Lw     = 3'b010;
    localparam logic [2:0] f3Lbu    = 3'b100;
    localparam logic [2:0] f3Lhu    = 3'b101;

    localparam logic [2:0] f3Sb     = 3'b000;
    localparam logic [2:0] f3Sh     = 3'b001;
    localparam logic [2:0] f3Sw     = 3'b010;

    localparam logic [2:0] f3AddSub = 3'b000; // SUB only in register form
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // Funct7 bit 5, picks SUB and SRA
    localparam int altFunct7Bit = 30;

    // NONE marks an unknown instruction
    typedef enum logic [2:0] {NONE, R, I, S, B, U, J} immFormat_t;

    typedef enum logic [3:0] {
        COPY2, ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } aluOp_t;

    typedef enum logic {RS1, PC} aluSrc1_t;

    typedef enum logic {RS2, IMM} aluSrc2_t;

endpackage

`default_nettype wire
